/* verilog/io_pkg.sv */
package io_pkg;

    // Request word widths
    localparam int ADDR_WIDTH = 15;
    localparam int DATA_WIDTH = 16;

    localparam int NUM_IRQS = 8;

    // Port addresses, compared as {addr, 1'b0}
    localparam logic [15:0] LEDS_PORT = 16'hfffe;
    localparam logic [15:0] IRQ_PORT = 16'hfff6;
    localparam logic [15:0] TIMER_PORT = 16'h0040; // Reload/count, then control

    // A timer write is either a reload value or the control fields
    typedef union packed {
        logic [15:0] value;
        struct packed {
            logic [13:0] reserved; // Reads as zero
            logic irq_enable;
            logic enable;
        } ctrl;
    } timer_word_u;

endpackage

/* verilog/io_req_if.sv */
`timescale 1ns/1ns

interface io_req_if
    import io_pkg::*;
();

    logic [ADDR_WIDTH-1:0] addr; // Word address
    logic [DATA_WIDTH-1:0] wdata;
    logic wr_en;
    logic [1:0] bytesel; // Low and high byte lanes

    // The decoder only looks at the address
    modport master (
        input addr
    );

    modport target (
        input addr,
        input wdata,
        input wr_en,
        input bytesel
    );

endinterface

/* verilog/io_bus_decoder.sv */
`timescale 1ns/1ns

module io_bus_decoder
    import io_pkg::*;
(
    input logic clk,
    input logic reset,
    io_req_if.master req,
    input logic access,
    output logic leds_cs,
    output logic timer_cs,
    output logic irq_cs,
    input logic [DATA_WIDTH-1:0] leds_rdata,
    input logic [DATA_WIDTH-1:0] timer_rdata,
    input logic [DATA_WIDTH-1:0] irq_rdata,
    input logic leds_ack,
    input logic timer_ack,
    input logic irq_ack,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic ack
);

    logic [15:0] byte_addr;
    logic default_cs;
    logic default_ack;

    assign byte_addr = {req.addr, 1'b0};

    always_comb begin
        leds_cs = 1'b0;
        timer_cs = 1'b0;
        irq_cs = 1'b0;
        default_cs = 1'b0;

        if (access) begin
            if (byte_addr == LEDS_PORT) begin
                leds_cs = 1'b1;
            end else if (byte_addr == IRQ_PORT) begin
                irq_cs = 1'b1;
            end else if (byte_addr[15:2] == TIMER_PORT[15:2]) begin
                timer_cs = 1'b1; // Two words
            end else begin
                default_cs = 1'b1; // Nobody claims it
            end
        end
    end

    // Unclaimed accesses still complete
    always_ff @(posedge clk) begin
        if (reset) begin
            default_ack <= 1'b0;
        end else begin
            default_ack <= default_cs & ~default_ack;
        end
    end

    // Idle targets drive zero, so a plain OR is enough
    assign rdata = leds_rdata | timer_rdata | irq_rdata;
    assign ack = leds_ack | timer_ack | irq_ack | default_ack;

endmodule

/* verilog/leds_register.sv */
`timescale 1ns/1ns

module leds_register
    import io_pkg::*;
#(
    parameter int NUM_LEDS = 8
)
(
    input logic clk,
    input logic reset,
    io_req_if.target req,
    input logic cs,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic ack,
    output logic [NUM_LEDS-1:0] leds
);

    logic [DATA_WIDTH-1:0] leds_ext;

    always_comb begin
        leds_ext = '0;
        leds_ext[NUM_LEDS-1:0] = leds; // Zero extended
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            leds <= '0;
        end else begin
            ack <= cs & ~ack;
            if (cs && !ack && req.wr_en) begin
                for (int i = 0; i < NUM_LEDS; i++) begin
                    if (req.bytesel[i / 8]) begin
                        leds[i] <= req.wdata[i]; // Enabled lanes only
                    end
                end
            end
        end
    end

    assign rdata = ack ? leds_ext : '0;

endmodule

/* verilog/timer_registers.sv */
`timescale 1ns/1ns

module timer_registers
    import io_pkg::*;
(
    input logic clk,
    input logic reset,
    io_req_if.target req,
    input logic cs,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic ack,
    input logic [15:0] count,
    input logic tick,
    output logic [15:0] reload,
    output logic enable,
    output logic timer_irq
);

    timer_word_u wr_word;
    timer_word_u rd_ctrl;
    logic irq_enable;
    logic write_strobe;

    assign wr_word = req.wdata;
    assign write_strobe = cs & ~ack & req.wr_en;

    always_comb begin
        rd_ctrl = '0;
        rd_ctrl.ctrl.enable = enable;
        rd_ctrl.ctrl.irq_enable = irq_enable;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            reload <= '0;
            enable <= 1'b0;
            irq_enable <= 1'b0;
        end else begin
            ack <= cs & ~ack;
            if (write_strobe && !req.addr[0]) begin
                if (req.bytesel[0]) begin
                    reload[7:0] <= wr_word.value[7:0];
                end
                if (req.bytesel[1]) begin
                    reload[15:8] <= wr_word.value[15:8];
                end
            end
            if (write_strobe && req.addr[0] && req.bytesel[0]) begin
                enable <= wr_word.ctrl.enable; // Control word
                irq_enable <= wr_word.ctrl.irq_enable;
            end
        end
    end

    // Offset 0 reads the live count
    assign rdata = !ack ? '0 : (req.addr[0] ? rd_ctrl.value : count);

    assign timer_irq = tick & irq_enable;

endmodule

/* verilog/timer_counter.sv */
`timescale 1ns/1ns

module timer_counter #(
    parameter int PRESCALE = 4
)
(
    input logic clk,
    input logic reset,
    input logic [15:0] reload,
    input logic enable,
    output logic [15:0] count,
    output logic tick
);

    localparam int PRE_WIDTH = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic [PRE_WIDTH-1:0] pre_count;
    logic step;

    assign step = pre_count == PRE_WIDTH'(PRESCALE - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            pre_count <= '0;
            count <= '0;
            tick <= 1'b0;
        end else if (!enable) begin
            pre_count <= '0;
            count <= reload; // Parked at reload
            tick <= 1'b0;
        end else begin
            tick <= 1'b0;
            pre_count <= step ? '0 : pre_count + 1'b1;
            if (step) begin
                if (count == 16'h0000) begin
                    count <= reload;
                    tick <= 1'b1; // Terminal count
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/irq_controller.sv */
`timescale 1ns/1ns

module irq_controller
    import io_pkg::*;
(
    input logic clk,
    input logic reset,
    io_req_if.target req,
    input logic cs,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic ack,
    input logic [NUM_IRQS-1:0] irq_lines,
    output logic intr
);

    logic [NUM_IRQS-1:0] pending;
    logic [NUM_IRQS-1:0] mask;
    logic [NUM_IRQS-1:0] clear;
    logic write_strobe;
    logic [DATA_WIDTH-1:0] rd_word;

    assign write_strobe = cs & ~ack & req.wr_en;

    // Write one to clear, low lane only
    assign clear = (write_strobe && req.bytesel[0]) ? req.wdata[NUM_IRQS-1:0] : '0;

    always_comb begin
        rd_word = '0;
        rd_word[NUM_IRQS-1:0] = pending;
        rd_word[8 +: NUM_IRQS] = mask; // High byte
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            pending <= '0;
            mask <= '0;
            intr <= 1'b0;
        end else begin
            ack <= cs & ~ack;
            pending <= (pending & ~clear) | irq_lines; // A live line wins
            if (write_strobe && req.bytesel[1]) begin
                mask <= req.wdata[8 +: NUM_IRQS];
            end
            intr <= |(pending & mask);
        end
    end

    assign rdata = ack ? rd_word : '0;

endmodule

/* verilog/io_subsystem.sv */
`timescale 1ns/1ns

module io_subsystem
    import io_pkg::*;
#(
    parameter int NUM_LEDS = 8,
    parameter int PRESCALE = 4
)
(
    input logic clk,
    input logic reset,
    input logic io_access,
    input logic [ADDR_WIDTH-1:0] io_addr,
    input logic [DATA_WIDTH-1:0] io_wdata,
    input logic io_wr_en,
    input logic [1:0] io_bytesel,
    output logic [DATA_WIDTH-1:0] io_rdata,
    output logic io_ack,
    input logic [NUM_IRQS-2:0] ext_irq,
    output logic [NUM_LEDS-1:0] leds,
    output logic intr
);

    logic leds_cs;
    logic timer_cs;
    logic irq_cs;
    logic [DATA_WIDTH-1:0] leds_rdata;
    logic [DATA_WIDTH-1:0] timer_rdata;
    logic [DATA_WIDTH-1:0] irq_rdata;
    logic leds_ack;
    logic timer_ack;
    logic irq_ack;
    logic [15:0] reload;
    logic enable;
    logic [15:0] count;
    logic tick;
    logic timer_irq;
    logic [NUM_IRQS-1:0] irq_lines;

    io_req_if req ();

    assign req.addr = io_addr;
    assign req.wdata = io_wdata;
    assign req.wr_en = io_wr_en;
    assign req.bytesel = io_bytesel;

    assign irq_lines = {ext_irq, timer_irq}; // Timer on line 0

    io_bus_decoder i_decoder (
        .clk(clk),
        .reset(reset),
        .req(req.master),
        .access(io_access),
        .leds_cs(leds_cs),
        .timer_cs(timer_cs),
        .irq_cs(irq_cs),
        .leds_rdata(leds_rdata),
        .timer_rdata(timer_rdata),
        .irq_rdata(irq_rdata),
        .leds_ack(leds_ack),
        .timer_ack(timer_ack),
        .irq_ack(irq_ack),
        .rdata(io_rdata),
        .ack(io_ack)
    );

    leds_register #(
        .NUM_LEDS(NUM_LEDS)
    ) i_leds_register (
        .clk(clk),
        .reset(reset),
        .req(req.target),
        .cs(leds_cs),
        .rdata(leds_rdata),
        .ack(leds_ack),
        .leds(leds)
    );

    timer_registers i_timer_registers (
        .clk(clk),
        .reset(reset),
        .req(req.target),
        .cs(timer_cs),
        .rdata(timer_rdata),
        .ack(timer_ack),
        .count(count),
        .tick(tick),
        .reload(reload),
        .enable(enable),
        .timer_irq(timer_irq)
    );

    timer_counter #(
        .PRESCALE(PRESCALE)
    ) i_timer_counter (
        .clk(clk),
        .reset(reset),
        .reload(reload),
        .enable(enable),
        .count(count),
        .tick(tick)
    );

    irq_controller i_irq_controller (
        .clk(clk),
        .reset(reset),
        .req(req.target),
        .cs(irq_cs),
        .rdata(irq_rdata),
        .ack(irq_ack),
        .irq_lines(irq_lines),
        .intr(intr)
    );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 100
)
(
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

/* verif/io_subsystem_asserts.sv */
`timescale 1ns/1ns

module io_subsystem_asserts (
    input logic clk,
    input logic reset,
    input logic io_access,
    input logic io_ack,
    input logic intr
);

    ack_needs_access: assert property (@(posedge clk) disable iff (reset)
        io_ack |-> $past(io_access))
        else $error("io_ack high without io_access on the previous cycle");

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        io_ack |=> !io_ack)
        else $error("io_ack held high for more than one cycle");

    // Fixed latency at the top level
    ack_after_access: assert property (@(posedge clk) disable iff (reset)
        $rose(io_access) |=> io_ack)
        else $error("io_ack missing one cycle after io_access rose");

    quiet_in_reset: assert property (@(posedge clk)
        $past(reset) |-> (!io_ack && !intr))
        else $error("io_ack or intr high while in reset");

endmodule

bind io_subsystem io_subsystem_asserts i_io_subsystem_asserts (
    .clk(clk),
    .reset(reset),
    .io_access(io_access),
    .io_ack(io_ack),
    .intr(intr)
);

/* verif/io_subsystem_tb.sv */
`timescale 1ns/1ns

module io_subsystem_tb
    import io_pkg::*;
();

    localparam int NUM_LEDS = 8;
    localparam int PRESCALE = 4;
    localparam int DRIVE_DELAY = 10;
    localparam int ACK_LIMIT = 4;
    localparam logic [15:0] TIMER_RELOAD = 16'd3;
    localparam int TICK_BOUND = 2 * (int'(TIMER_RELOAD) + 1) * PRESCALE;
    localparam logic [ADDR_WIDTH-1:0] LEDS_ADDR = LEDS_PORT[15:1];
    localparam logic [ADDR_WIDTH-1:0] IRQ_ADDR = IRQ_PORT[15:1];
    localparam logic [ADDR_WIDTH-1:0] TIMER_ADDR = TIMER_PORT[15:1];
    localparam logic [ADDR_WIDTH-1:0] TIMER_CTRL_ADDR = TIMER_ADDR + 1'b1;
    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ = 2'd1;
    localparam logic [1:0] OP_PULSE = 2'd2; // Data holds the ext_irq lines

    typedef struct packed {
        logic [1:0] op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [15:0] data;
        logic [1:0] bytesel;
        logic [15:0] expected;
        logic use_model; // Expected value comes from the model
        logic rand_data;
    } entry_t;

    logic clk;
    logic reset;
    logic io_access;
    logic [ADDR_WIDTH-1:0] io_addr;
    logic [DATA_WIDTH-1:0] io_wdata;
    logic io_wr_en;
    logic [1:0] io_bytesel;
    logic [DATA_WIDTH-1:0] io_rdata;
    logic io_ack;
    logic [NUM_IRQS-2:0] ext_irq;
    logic [NUM_LEDS-1:0] leds;
    logic intr;

    logic [15:0] leds_m;
    logic [NUM_IRQS-1:0] mask_m;
    logic [NUM_IRQS-1:0] pending_m;
    logic [15:0] reload_m;
    timer_word_u ctrl_m;

    entry_t stim_q[$];
    logic stim_ready = 1'b0;
    integer seed = 32'h5a9b;
    int errors = 0;
    int checks = 0;
    int cycle_count = 0;

    tb_clock_gen #(
        .PERIOD(100)
    ) i_clock_gen (
        .clk(clk)
    );

    io_subsystem #(
        .NUM_LEDS(NUM_LEDS),
        .PRESCALE(PRESCALE)
    ) i_io_subsystem (
        .clk(clk),
        .reset(reset),
        .io_access(io_access),
        .io_addr(io_addr),
        .io_wdata(io_wdata),
        .io_wr_en(io_wr_en),
        .io_bytesel(io_bytesel),
        .io_rdata(io_rdata),
        .io_ack(io_ack),
        .ext_irq(ext_irq),
        .leds(leds),
        .intr(intr)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic void add_entry(input logic [1:0] op, input logic [ADDR_WIDTH-1:0] addr,
            input logic [15:0] data, input logic [1:0] bytesel, input logic [15:0] expected,
            input logic use_model, input logic rand_data);
        entry_t e;
        e = '{op, addr, data, bytesel, expected, use_model, rand_data};
        stim_q.push_back(e);
    endfunction

    function automatic void build_stimulus();
        // op, address, data, bytesel, expected, from model, random data
        add_entry(OP_READ, LEDS_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b0, 1'b0);
        add_entry(OP_WRITE, LEDS_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b0, 1'b1);
        add_entry(OP_READ, LEDS_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b1, 1'b0);
        add_entry(OP_WRITE, LEDS_ADDR, 16'h0000, 2'b01, 16'h0000, 1'b0, 1'b1);
        add_entry(OP_READ, LEDS_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b1, 1'b0);
        add_entry(OP_WRITE, LEDS_ADDR, 16'h0000, 2'b10, 16'h0000, 1'b0, 1'b1);
        add_entry(OP_READ, LEDS_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b1, 1'b0);
        add_entry(OP_WRITE, LEDS_ADDR, 16'h0000, 2'b00, 16'h0000, 1'b0, 1'b1);
        add_entry(OP_READ, LEDS_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b1, 1'b0);
        add_entry(OP_READ, 15'h0000, 16'h0000, 2'b11, 16'h0000, 1'b0, 1'b0); // Unmapped
        add_entry(OP_WRITE, 15'h1234, 16'hffff, 2'b11, 16'h0000, 1'b0, 1'b0);
        add_entry(OP_READ, 15'h1234, 16'h0000, 2'b11, 16'h0000, 1'b0, 1'b0);
        add_entry(OP_READ, 15'h0022, 16'h0000, 2'b11, 16'h0000, 1'b0, 1'b0);
        add_entry(OP_READ, TIMER_CTRL_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b0, 1'b0);
        add_entry(OP_WRITE, TIMER_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b0, 1'b1);
        add_entry(OP_READ, TIMER_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b1, 1'b0);
        add_entry(OP_WRITE, TIMER_ADDR, 16'h00a5, 2'b01, 16'h0000, 1'b0, 1'b0);
        add_entry(OP_READ, TIMER_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b1, 1'b0);
        add_entry(OP_WRITE, TIMER_CTRL_ADDR, 16'hfffe, 2'b11, 16'h0000, 1'b0, 1'b0);
        add_entry(OP_READ, TIMER_CTRL_ADDR, 16'h0000, 2'b11, 16'h0002, 1'b0, 1'b0);
        add_entry(OP_WRITE, IRQ_ADDR, 16'h0600, 2'b10, 16'h0000, 1'b0, 1'b0);
        add_entry(OP_PULSE, IRQ_ADDR, 16'h0002, 2'b00, 16'h0000, 1'b0, 1'b0); // Line 2
        add_entry(OP_READ, IRQ_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b1, 1'b0);
        add_entry(OP_PULSE, IRQ_ADDR, 16'h0041, 2'b00, 16'h0000, 1'b0, 1'b0); // Lines 1, 7
        add_entry(OP_READ, IRQ_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b1, 1'b0);
        add_entry(OP_WRITE, IRQ_ADDR, 16'h0006, 2'b01, 16'h0000, 1'b0, 1'b0);
        add_entry(OP_READ, IRQ_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b1, 1'b0);
        add_entry(OP_WRITE, IRQ_ADDR, 16'hff02, 2'b11, 16'h0000, 1'b0, 1'b0);
        add_entry(OP_READ, IRQ_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b1, 1'b0);
        add_entry(OP_WRITE, IRQ_ADDR, 16'h0080, 2'b01, 16'h0000, 1'b0, 1'b0);
        add_entry(OP_READ, IRQ_ADDR, 16'h0000, 2'b11, 16'h0000, 1'b1, 1'b0);
    endfunction

    function automatic logic [15:0] model_read(input logic [ADDR_WIDTH-1:0] addr);
        logic [15:0] word;
        word = '0;
        if (addr == LEDS_ADDR) begin
            word = leds_m;
        end else if (addr == IRQ_ADDR) begin
            word = {mask_m, pending_m};
        end else if (addr == TIMER_ADDR) begin
            word = reload_m; // Count parks at reload while disabled
        end else if (addr == TIMER_CTRL_ADDR) begin
            word = ctrl_m.value;
        end
        return word;
    endfunction

    function automatic void model_write(input logic [ADDR_WIDTH-1:0] addr,
            input logic [15:0] data, input logic [1:0] bytesel);
        timer_word_u word;
        word.value = data;
        if (addr == LEDS_ADDR) begin
            for (int i = 0; i < NUM_LEDS; i++) begin
                if (bytesel[i / 8]) begin
                    leds_m[i] = data[i];
                end
            end
        end else if (addr == IRQ_ADDR) begin
            if (bytesel[0]) begin
                pending_m = pending_m & ~data[7:0];
            end
            if (bytesel[1]) begin
                mask_m = data[15:8];
            end
        end else if (addr == TIMER_ADDR) begin
            if (bytesel[0]) begin
                reload_m[7:0] = data[7:0];
            end
            if (bytesel[1]) begin
                reload_m[15:8] = data[15:8];
            end
        end else if (addr == TIMER_CTRL_ADDR && bytesel[0]) begin
            ctrl_m = '0;
            ctrl_m.ctrl.enable = word.ctrl.enable;
            ctrl_m.ctrl.irq_enable = word.ctrl.irq_enable;
        end
    endfunction

    task automatic check_equal(input string name, input logic [15:0] got,
            input logic [15:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic bus_access(input logic wr, input logic [ADDR_WIDTH-1:0] addr,
            input logic [15:0] data, input logic [1:0] bytesel, output logic [15:0] rdata);
        int waited;
        @(posedge clk);
        #DRIVE_DELAY;
        io_access = 1'b1;
        io_addr = addr;
        io_wdata = data;
        io_wr_en = wr;
        io_bytesel = bytesel;
        waited = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end while (!io_ack && waited < ACK_LIMIT);
        rdata = io_rdata;
        checks++;
        if (!io_ack) begin
            errors++;
            $display("No acknowledge for address %h within %0d cycles", addr, ACK_LIMIT);
        end else if (waited != 1) begin
            errors++;
            $display("Acknowledge for address %h took %0d cycles instead of one", addr, waited);
        end
        io_access = 1'b0;
        io_wr_en = 1'b0;
    endtask

    task automatic write_word(input logic [ADDR_WIDTH-1:0] addr, input logic [15:0] data,
            input logic [1:0] bytesel);
        logic [15:0] rdata;
        bus_access(1'b1, addr, data, bytesel, rdata);
        model_write(addr, data, bytesel);
    endtask

    task automatic read_check(input logic [ADDR_WIDTH-1:0] addr, input logic [15:0] expected);
        logic [15:0] rdata;
        bus_access(1'b0, addr, 16'h0000, 2'b11, rdata);
        check_equal($sformatf("io_rdata at %h", addr), rdata, expected);
    endtask

    task automatic pulse_irq(input logic [NUM_IRQS-2:0] lines);
        @(posedge clk);
        #DRIVE_DELAY;
        ext_irq = lines;
        @(posedge clk);
        #DRIVE_DELAY;
        ext_irq = '0;
        pending_m = pending_m | {lines, 1'b0};
    endtask

    // Registered, so look one edge later
    task automatic check_intr();
        @(posedge clk);
        #DRIVE_DELAY;
        check_equal("intr", 16'(intr), 16'(|(pending_m & mask_m)));
    endtask

    task automatic apply_entry(input entry_t e);
        logic [31:0] rnd;
        logic [15:0] data;
        logic [15:0] expected;
        data = e.data;
        if (e.rand_data) begin
            rnd = $random(seed);
            data = rnd[15:0];
        end
        expected = e.use_model ? model_read(e.addr) : e.expected;
        case (e.op)
            OP_WRITE: write_word(e.addr, data, e.bytesel);
            OP_READ: read_check(e.addr, expected);
            default: pulse_irq(data[NUM_IRQS-2:0]);
        endcase
        check_equal("leds", 16'(leds), leds_m);
        check_intr();
    endtask

    task automatic run_timer_test();
        timer_word_u ctrl;
        logic [15:0] rdata;
        int start;
        ctrl = '0;
        ctrl.ctrl.enable = 1'b1;
        ctrl.ctrl.irq_enable = 1'b1;
        write_word(TIMER_ADDR, TIMER_RELOAD, 2'b11);
        write_word(TIMER_CTRL_ADDR, ctrl.value, 2'b01);
        start = cycle_count;
        rdata = '0;
        while (!rdata[0] && cycle_count - start <= TICK_BOUND) begin
            bus_access(1'b0, IRQ_ADDR, 16'h0000, 2'b11, rdata); // Poll pending
        end
        checks++;
        if (!rdata[0]) begin
            errors++;
            $display("Timer interrupt not pending within %0d cycles of enable", TICK_BOUND);
        end
        pending_m[0] = 1'b1;
        ctrl = '0;
        write_word(TIMER_CTRL_ADDR, ctrl.value, 2'b01);
        write_word(IRQ_ADDR, 16'h0001, 2'b01);
        read_check(IRQ_ADDR, model_read(IRQ_ADDR));
        read_check(TIMER_ADDR, model_read(TIMER_ADDR));
        check_intr();
    endtask

    initial begin
        int limit;
        wait (stim_ready);
        limit = stim_q.size() * 20 + TICK_BOUND;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished", limit);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        reset = 1'b1;
        io_access = 1'b0;
        io_addr = '0;
        io_wdata = '0;
        io_wr_en = 1'b0;
        io_bytesel = 2'b00;
        ext_irq = '0;
        leds_m = '0;
        mask_m = '0;
        pending_m = '0;
        reload_m = '0;
        ctrl_m = '0;
        build_stimulus();
        stim_ready = 1'b1;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        check_equal("io_ack", 16'(io_ack), 16'h0000);
        check_equal("intr", 16'(intr), 16'h0000);
        check_equal("leds", 16'(leds), 16'h0000);
        foreach (stim_q[i]) begin
            apply_entry(stim_q[i]);
        end
        run_timer_test();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
verilog/io_pkg.sv
verilog/io_req_if.sv
verilog/io_bus_decoder.sv
verilog/leds_register.sv
verilog/timer_registers.sv
verilog/timer_counter.sv
verilog/irq_controller.sv
verilog/io_subsystem.sv
verif/tb_clock_gen.sv
verif/io_subsystem_asserts.sv
verif/io_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP := io_subsystem_tb
FILE_LIST := build.f
VFLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR := obj_dir
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(OBJ_DIR)

# A crash or a failed assertion also counts as a failing run
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TEST FAIL" >> $(LOG)
	@cat $(LOG)
	@! grep -q "TEST FAIL" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
